//--- common/audio_pkg.sv
`default_nettype none

package audio_pkg;

  // Audio sample and fixed-point filter word
  localparam int AUDIO_W = 16;
  localparam int ACC_W   = 27;
  localparam int FRAC_W  = 23;

  // Level field taken from the filter output
  localparam int LEVEL_W   = 11;
  localparam int LEVEL_LSB = 12;

  // Peak hold, then linear decay
  localparam int HOLD_SAMPLES = 8;
  localparam int HOLD_W       = $clog2(HOLD_SAMPLES + 1);
  localparam int DECAY_STEP   = 4;

  // Per-band peak meter state
  typedef enum logic [1:0] {
    track,
    hold,
    decay
  } meter_state_t;

endpackage

`default_nettype wire

//--- common/band_pkg.sv
`default_nettype none

package band_pkg;

  localparam int NUM_BANDS = 6;

  // Band edges by table index
  //   0: 10 Hz - 100 Hz
  //   1: 100 Hz - 500 Hz
  //   2: 500 Hz - 1 kHz
  //   3: 1 kHz - 5 kHz
  //   4: 5 kHz - 10 kHz
  //   5: 10 kHz - 20 kHz
  // All entries Q4.23, a1 is 1.0 and not stored

  localparam logic signed [audio_pkg::ACC_W-1:0] B1_TABLE [NUM_BANDS] = '{
    27'h0000048, 27'h0000583, 27'h0000892,
    27'h001D7E8, 27'h002C477, 27'h0093EDC
  };

  localparam logic signed [audio_pkg::ACC_W-1:0] B2_TABLE [NUM_BANDS] = '{
    27'h0000000, 27'h0000000, 27'h0000000,
    27'h0000000, 27'h0000000, 27'h0000000
  };

  localparam logic signed [audio_pkg::ACC_W-1:0] B3_TABLE [NUM_BANDS] = '{
    27'h7FFFF70, 27'h7FFF4FA, 27'h7FFEEDB,
    27'h7FC5030, 27'h7FA7711, 27'h7ED8248
  };

  localparam logic signed [audio_pkg::ACC_W-1:0] B4_TABLE [NUM_BANDS] = '{
    27'h0000000, 27'h0000000, 27'h0000000,
    27'h0000000, 27'h0000000, 27'h0000000
  };

  localparam logic signed [audio_pkg::ACC_W-1:0] B5_TABLE [NUM_BANDS] = '{
    27'h0000048, 27'h0000583, 27'h0000892,
    27'h001D7E8, 27'h002C477, 27'h0093EDC
  };

  localparam logic signed [audio_pkg::ACC_W-1:0] A2_TABLE [NUM_BANDS] = '{
    27'h6011140, 27'h604CAFA, 27'h60676FA,
    27'h633FA03, 27'h66A9DF0, 27'h7168071
  };

  localparam logic signed [audio_pkg::ACC_W-1:0] A3_TABLE [NUM_BANDS] = '{
    27'h3FCCDAA, 27'h3F1C349, 27'h3ED4B6C,
    27'h271581F, 27'h209FEAD, 27'h0FC755A
  };

  localparam logic signed [audio_pkg::ACC_W-1:0] A4_TABLE [NUM_BANDS] = '{
    27'h60330ED, 27'h60E18C3, 27'h61207B2,
    27'h68254EA, 27'h6BF5FBF, 27'h770E5BC
  };

  localparam logic signed [audio_pkg::ACC_W-1:0] A5_TABLE [NUM_BANDS] = '{
    27'h07EF029, 27'h07B58FB, 27'h07A360D,
    27'h058658B, 27'h05096DD, 27'h032F6A7
  };

endpackage

`default_nettype wire

//--- source/input_stage.sv
`timescale 1ns/1ns
`default_nettype none

module input_stage (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               enable,
  input  logic                               sample_valid,
  input  logic [audio_pkg::AUDIO_W-1:0]      audio_in_l,
  input  logic [audio_pkg::AUDIO_W-1:0]      audio_in_r,
  output logic [audio_pkg::AUDIO_W-1:0]      audio_out_l,
  output logic [audio_pkg::AUDIO_W-1:0]      audio_out_r,
  output logic signed [audio_pkg::ACC_W-1:0] x_sample,
  output logic                               x_valid
);

  import audio_pkg::*;

  // Straight pass-through, one register deep
  always_ff @(posedge clk) begin
    if (reset) begin
      audio_out_l <= '0;
      audio_out_r <= '0;
      x_valid     <= 1'b0;
    end else begin
      x_valid <= sample_valid && enable;
      if (sample_valid) begin
        audio_out_l <= audio_in_l;
        audio_out_r <= audio_in_r;
      end
    end
  end

  // Left channel into the filter word
  // sign-extend by four bits, pad seven zero fraction bits
  always_ff @(posedge clk) begin
    if (sample_valid) begin
      x_sample <= {{4{audio_in_l[AUDIO_W-1]}}, audio_in_l, {(ACC_W - AUDIO_W - 4){1'b0}}};
    end
  end

  // Filter bank needs a free cycle between samples
  assert property (@(posedge clk) disable iff (reset) sample_valid |=> !sample_valid)
    else $error("sample_valid high on consecutive cycles");

endmodule

`default_nettype wire

//--- filter_bank/band_filter.sv
`timescale 1ns/1ns
`default_nettype none

module band_filter #(
  parameter int band_index = 0
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic signed [audio_pkg::ACC_W-1:0] x_sample,
  input  logic                               x_valid,
  output logic signed [audio_pkg::ACC_W-1:0] y_sample,
  output logic                               y_valid
);

  import audio_pkg::*;
  import band_pkg::*;

  // Transposed direct-form II delay line
  logic signed [ACC_W-1:0] z1;
  logic signed [ACC_W-1:0] z2;
  logic signed [ACC_W-1:0] z3;
  logic signed [ACC_W-1:0] z4;

  logic signed [ACC_W-1:0] y;
  logic signed [ACC_W-1:0] z1_next;
  logic signed [ACC_W-1:0] z2_next;
  logic signed [ACC_W-1:0] z3_next;
  logic signed [ACC_W-1:0] z4_next;

  // Q4.23 multiply, full product shifted down and truncated
  function automatic logic signed [ACC_W-1:0] qmul(
    input logic signed [ACC_W-1:0] coef,
    input logic signed [ACC_W-1:0] data
  );
    logic signed [2*ACC_W-1:0] full;
    full = coef * data;
    return full[FRAC_W +: ACC_W];
  endfunction

  always_comb begin
    y = qmul(B1_TABLE[band_index], x_sample) + z1;

    // Feedback terms all use this sample's y
    z1_next = qmul(B2_TABLE[band_index], x_sample) + z2 - qmul(A2_TABLE[band_index], y);
    z2_next = qmul(B3_TABLE[band_index], x_sample) + z3 - qmul(A3_TABLE[band_index], y);
    z3_next = qmul(B4_TABLE[band_index], x_sample) + z4 - qmul(A4_TABLE[band_index], y);
    z4_next = qmul(B5_TABLE[band_index], x_sample) - qmul(A5_TABLE[band_index], y);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      z1       <= '0;
      z2       <= '0;
      z3       <= '0;
      z4       <= '0;
      y_sample <= '0;
      y_valid  <= 1'b0;
    end else begin
      y_valid <= x_valid;
      if (x_valid) begin
        y_sample <= y;
        z1       <= z1_next;
        z2       <= z2_next;
        z3       <= z3_next;
        z4       <= z4_next;
      end
    end
  end

  // Input stage strobe stays quiet while reset is high
  assert property (@(posedge clk) reset |-> !x_valid)
    else $error("x_valid high during reset");

endmodule

`default_nettype wire

//--- source/level_meter.sv
`timescale 1ns/1ns
`default_nettype none

module level_meter (
  input  logic                                                       clk,
  input  logic                                                       reset,
  input  logic                                                       enable,
  input  logic signed [band_pkg::NUM_BANDS-1:0][audio_pkg::ACC_W-1:0] filter_out,
  input  logic                                                       y_valid,
  output logic [band_pkg::NUM_BANDS-1:0][audio_pkg::LEVEL_W-1:0]      band_level,
  output logic                                                       level_valid
);

  import audio_pkg::*;
  import band_pkg::*;

  logic [LEVEL_W-1:0] inst [NUM_BANDS];
  logic [LEVEL_W-1:0] fall [NUM_BANDS];
  logic [HOLD_W-1:0]  hold_cnt [NUM_BANDS];
  meter_state_t       state [NUM_BANDS];

  // Rectify, and the next decayed level floored at the instant level
  always_comb begin
    for (int i = 0; i < NUM_BANDS; i++) begin
      if (filter_out[i][ACC_W-1])
        inst[i] = ~filter_out[i][LEVEL_LSB +: LEVEL_W];
      else
        inst[i] = filter_out[i][LEVEL_LSB +: LEVEL_W];
      if (band_level[i] > LEVEL_W'(DECAY_STEP))
        fall[i] = band_level[i] - LEVEL_W'(DECAY_STEP);
      else
        fall[i] = '0;
      if (fall[i] < inst[i])
        fall[i] = inst[i];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      level_valid <= 1'b0;
      for (int i = 0; i < NUM_BANDS; i++) begin
        band_level[i] <= '0;
        hold_cnt[i]   <= '0;
        state[i]      <= track;
      end
    end else begin
      level_valid <= y_valid;
      for (int i = 0; i < NUM_BANDS; i++) begin
        if (y_valid) begin
          case (state[i])
            track: begin
              if (inst[i] >= band_level[i]) begin
                band_level[i] <= inst[i];
                hold_cnt[i]   <= HOLD_W'(HOLD_SAMPLES);
                state[i]      <= hold;
              end else begin
                band_level[i] <= fall[i];
                if (fall[i] != inst[i])
                  state[i] <= decay;
              end
            end
            hold: begin
              if (inst[i] > band_level[i]) begin
                band_level[i] <= inst[i];
                hold_cnt[i]   <= HOLD_W'(HOLD_SAMPLES);
              end else begin
                hold_cnt[i] <= hold_cnt[i] - HOLD_W'(1);
                if (hold_cnt[i] == HOLD_W'(1))
                  state[i] <= decay;
              end
            end
            decay: begin
              band_level[i] <= fall[i];
              if (fall[i] == inst[i])
                state[i] <= track;
            end
            default: state[i] <= track;
          endcase
        end else if (!enable) begin
          // Meter off
          band_level[i] <= '0;
          hold_cnt[i]   <= '0;
          state[i]      <= track;
        end
      end
    end
  end

  // Shown level never drops under the sample it was updated from
  for (genvar g = 0; g < NUM_BANDS; g++) begin : g_check
    assert property (@(posedge clk) disable iff (reset)
      level_valid |-> band_level[g] >= $past(inst[g]))
      else $error("band %0d level below instant level", g);
  end

endmodule

`default_nettype wire

//--- source/spectrum_top.sv
`timescale 1ns/1ns
`default_nettype none

module spectrum_top (
  input  logic                                                 clk,
  input  logic                                                 reset,
  input  logic                                                 enable,
  input  logic                                                 sample_valid,
  input  logic [audio_pkg::AUDIO_W-1:0]                        audio_in_l,
  input  logic [audio_pkg::AUDIO_W-1:0]                        audio_in_r,
  output logic [audio_pkg::AUDIO_W-1:0]                        audio_out_l,
  output logic [audio_pkg::AUDIO_W-1:0]                        audio_out_r,
  output logic [band_pkg::NUM_BANDS-1:0][audio_pkg::LEVEL_W-1:0] band_level,
  output logic                                                 level_valid
);

  import audio_pkg::*;
  import band_pkg::*;

  logic signed [ACC_W-1:0]                 x_sample;
  logic                                    x_valid;
  logic signed [NUM_BANDS-1:0][ACC_W-1:0]  filter_out;
  logic [NUM_BANDS-1:0]                    band_valid;

  input_stage u_input_stage (
    .clk          (clk),
    .reset        (reset),
    .enable       (enable),
    .sample_valid (sample_valid),
    .audio_in_l   (audio_in_l),
    .audio_in_r   (audio_in_r),
    .audio_out_l  (audio_out_l),
    .audio_out_r  (audio_out_r),
    .x_sample     (x_sample),
    .x_valid      (x_valid)
  );

  // All bands share timing, band 0 strobe drives the meter
  for (genvar i = 0; i < NUM_BANDS; i++) begin : g_band
    band_filter #(
      .band_index (i)
    ) u_band_filter (
      .clk      (clk),
      .reset    (reset),
      .x_sample (x_sample),
      .x_valid  (x_valid),
      .y_sample (filter_out[i]),
      .y_valid  (band_valid[i])
    );
  end

  level_meter u_level_meter (
    .clk         (clk),
    .reset       (reset),
    .enable      (enable),
    .filter_out  (filter_out),
    .y_valid     (band_valid[0]),
    .band_level  (band_level),
    .level_valid (level_valid)
  );

endmodule

`default_nettype wire

//--- verif/spectrum_tb.sv
`timescale 1ns/1ns
`default_nettype none

module spectrum_tb;

  import audio_pkg::*;
  import band_pkg::*;

  localparam int MAX_RECORDS = 64;
  localparam int REC_W = 108;
  localparam int LV_TIMEOUT = 10;

  logic clk;
  logic reset;
  logic enable;
  logic sample_valid;
  logic [AUDIO_W-1:0] audio_in_l;
  logic [AUDIO_W-1:0] audio_in_r;
  logic [AUDIO_W-1:0] audio_out_l;
  logic [AUDIO_W-1:0] audio_out_r;
  logic [NUM_BANDS-1:0][LEVEL_W-1:0] band_level;
  logic level_valid;

  logic [REC_W-1:0] records [MAX_RECORDS];

  // Reference filter state and meter
  logic signed [ACC_W-1:0] mz1 [NUM_BANDS];
  logic signed [ACC_W-1:0] mz2 [NUM_BANDS];
  logic signed [ACC_W-1:0] mz3 [NUM_BANDS];
  logic signed [ACC_W-1:0] mz4 [NUM_BANDS];
  logic [LEVEL_W-1:0] ref_level [NUM_BANDS];
  int ref_cnt [NUM_BANDS];
  meter_state_t ref_state [NUM_BANDS];

  logic [31:0] rng;
  int errors;
  int timeouts;
  int idx;

  spectrum_top UUT (
    .clk          (clk),
    .reset        (reset),
    .enable       (enable),
    .sample_valid (sample_valid),
    .audio_in_l   (audio_in_l),
    .audio_in_r   (audio_in_r),
    .audio_out_l  (audio_out_l),
    .audio_out_r  (audio_out_r),
    .band_level   (band_level),
    .level_valid  (level_valid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Q4.23 product, shifted down by the fraction bits and cut to the word
  function automatic logic signed [ACC_W-1:0] fixmul(
    input logic signed [ACC_W-1:0] c,
    input logic signed [ACC_W-1:0] d
  );
    longint p;
    p = longint'(c) * longint'(d);
    p = p >>> FRAC_W;
    return ACC_W'(p);
  endfunction

  task automatic clear_meter();
    for (int b = 0; b < NUM_BANDS; b++) begin
      ref_level[b] = '0;
      ref_cnt[b] = 0;
      ref_state[b] = track;
    end
  endtask

  task automatic clear_model();
    for (int b = 0; b < NUM_BANDS; b++) begin
      mz1[b] = '0;
      mz2[b] = '0;
      mz3[b] = '0;
      mz4[b] = '0;
    end
    clear_meter();
  endtask

  task automatic model_sample(input logic [AUDIO_W-1:0] left);
    logic signed [ACC_W-1:0] x;
    logic signed [ACC_W-1:0] y;
    logic [LEVEL_W-1:0] inst;
    logic [LEVEL_W-1:0] fall;
    x = {{4{left[AUDIO_W-1]}}, left, 7'b0};
    for (int b = 0; b < NUM_BANDS; b++) begin
      y = fixmul(B1_TABLE[b], x) + mz1[b];
      mz1[b] = fixmul(B2_TABLE[b], x) + mz2[b] - fixmul(A2_TABLE[b], y);
      mz2[b] = fixmul(B3_TABLE[b], x) + mz3[b] - fixmul(A3_TABLE[b], y);
      mz3[b] = fixmul(B4_TABLE[b], x) + mz4[b] - fixmul(A4_TABLE[b], y);
      mz4[b] = fixmul(B5_TABLE[b], x) - fixmul(A5_TABLE[b], y);
      inst = y[ACC_W-1] ? ~y[LEVEL_LSB +: LEVEL_W] : y[LEVEL_LSB +: LEVEL_W];
      fall = (ref_level[b] > DECAY_STEP) ? ref_level[b] - DECAY_STEP : '0;
      if (fall < inst)
        fall = inst;
      case (ref_state[b])
        track: begin
          if (inst >= ref_level[b]) begin
            ref_level[b] = inst;
            ref_cnt[b] = HOLD_SAMPLES;
            ref_state[b] = hold;
          end else begin
            ref_level[b] = fall;
            if (fall != inst)
              ref_state[b] = decay;
          end
        end
        hold: begin
          if (inst > ref_level[b]) begin
            ref_level[b] = inst;
            ref_cnt[b] = HOLD_SAMPLES;
          end else begin
            ref_cnt[b] = ref_cnt[b] - 1;
            if (ref_cnt[b] == 0)
              ref_state[b] = decay;
          end
        end
        default: begin
          ref_level[b] = fall;
          if (fall == inst)
            ref_state[b] = track;
        end
      endcase
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    repeat (2) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic check_levels(input logic [REC_W-1:0] rec);
    logic [11:0] field;
    logic [LEVEL_W-1:0] expect_lvl;
    for (int b = 0; b < NUM_BANDS; b++) begin
      field = rec[71-12*b -: 12];
      // All ones in the field hands the band over to the meter model
      expect_lvl = (field == 12'hFFF) ? ref_level[b] : field[LEVEL_W-1:0];
      if (band_level[b] !== expect_lvl) begin
        $display("error %0t: band %0d expected %0d got %0d",
                 $time, b, expect_lvl, band_level[b]);
        errors++;
      end
    end
  endtask

  task automatic run_record(input logic [REC_W-1:0] rec);
    logic [3:0] ctrl;
    logic [AUDIO_W-1:0] l;
    logic [AUDIO_W-1:0] r;
    int n;
    int gap;
    ctrl = rec[107:104];
    l = rec[103:88];
    r = rec[87:72];
    if (ctrl[1]) begin
      apply_reset();
      clear_model();
    end
    @(negedge clk);
    enable = ctrl[0];
    audio_in_l = l;
    audio_in_r = r;
    sample_valid = 1'b1;
    @(negedge clk);
    sample_valid = 1'b0;
    n = 1;
    if (audio_out_l !== l || audio_out_r !== r) begin
      $display("error %0t: audio out %h/%h expected %h/%h",
               $time, audio_out_l, audio_out_r, l, r);
      errors++;
    end
    if (ctrl[0]) begin
      model_sample(l);
      while (!level_valid && n < LV_TIMEOUT) begin
        @(negedge clk);
        n++;
      end
      if (!level_valid) begin
        $display("level_valid never arrived");
        timeouts++;
        errors++;
      end else begin
        if (n != 3) begin
          $display("error %0t: level_valid after %0d cycles, expected 3", $time, n);
          errors++;
        end
        check_levels(rec);
      end
    end else begin
      // Meter off, filter state kept
      clear_meter();
      for (n = 1; n < 6; n++) begin
        if (level_valid) begin
          $display("error %0t: level_valid pulsed while disabled", $time);
          errors++;
        end
        @(negedge clk);
      end
      check_levels(rec);
    end
    rng = xorshift(rng);
    gap = 2 + int'(rng % 4);
    repeat (gap) @(negedge clk);
  endtask

  initial begin
    reset = 1'b0;
    enable = 1'b0;
    sample_valid = 1'b0;
    audio_in_l = '0;
    audio_in_r = '0;
    errors = 0;
    timeouts = 0;
    rng = 32'h46db;
    $readmemh("verif/spectrum_stimulus.txt", records);
    @(posedge clk);
    apply_reset();
    clear_model();
    @(negedge clk);
    if (audio_out_l !== '0 || audio_out_r !== '0 || band_level !== '0 || level_valid !== 1'b0) begin
      $display("error %0t: outputs not cleared after reset", $time);
      errors++;
    end
    if ($isunknown(records[0])) begin
      $display("stimulus file held no records");
      errors++;
    end
    idx = 0;
    while (idx < MAX_RECORDS && !$isunknown(records[idx])) begin
      run_record(records[idx]);
      idx++;
    end
    $display("%0d records, %0d errors, %0d timeouts", idx, errors, timeouts);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/spectrum_stimulus.txt
// ctrl (bit 1 reset first, bit 0 enable), left, right, levels of band 0 to band 5
// a level of FFF is predicted by the testbench meter model
1_4000_1234_000_000_000_007_00B_024
1_0000_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_0000_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_0000_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_0000_0000_FFF_FFF_FFF_FFF_FFF_FFF
3_8000_0000_000_000_000_00E_016_049
1_0000_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_0000_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_2000_2000_FFF_FFF_FFF_FFF_FFF_FFF
1_2000_2000_FFF_FFF_FFF_FFF_FFF_FFF
1_2000_2000_FFF_FFF_FFF_FFF_FFF_FFF
1_2000_2000_FFF_FFF_FFF_FFF_FFF_FFF
1_5A82_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_7FFF_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_5A82_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_0000_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_A57E_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_8001_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_A57E_0000_FFF_FFF_FFF_FFF_FFF_FFF
0_1111_2222_000_000_000_000_000_000
0_3333_4444_000_000_000_000_000_000
1_0000_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_7FFF_7FFF_FFF_FFF_FFF_FFF_FFF_FFF
1_8001_8001_FFF_FFF_FFF_FFF_FFF_FFF
1_7FFF_7FFF_FFF_FFF_FFF_FFF_FFF_FFF
1_0000_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_0000_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_0000_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_0000_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_0000_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_0000_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_0000_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_0000_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_0000_0000_FFF_FFF_FFF_FFF_FFF_FFF
1_0000_0000_FFF_FFF_FFF_FFF_FFF_FFF

//--- filelist.f
common/audio_pkg.sv
common/band_pkg.sv
source/input_stage.sv
filter_bank/band_filter.sv
source/level_meter.sv
source/spectrum_top.sv
verif/spectrum_tb.sv
